// File: hw/bridge_bus_pkg.sv
// Bus side widths, address window constants and queue entry layout
// Data word union seen as one word or as two half-words
`default_nettype none

package bridge_bus_pkg;

    localparam int BUS_ADDR_W   = 32;
    localparam int BUS_DATA_W   = 32;
    localparam int BUS_MASK_W   = 4;
    localparam int BUS_HALF_W   = BUS_DATA_W / 2;

    // Address window, top nibble selects the bridge
    localparam logic [3:0] WINDOW_TAG = 4'h4;
    localparam int ADDR_TAG_LSB = 28;
    localparam int ADDR_IDX_LSB = 2;                // Word index starts above byte offset
    localparam int WORD_IDX_W   = 23;               // Bits 24..2, bits 27..25 alias

    // Queue entry {we, idx, data, mask}
    localparam int REQ_W        = 60;
    localparam int REQ_MASK_LSB = 0;
    localparam int REQ_DATA_LSB = REQ_MASK_LSB + BUS_MASK_W;
    localparam int REQ_IDX_LSB  = REQ_DATA_LSB + BUS_DATA_W;
    localparam int REQ_WE_BIT   = REQ_IDX_LSB + WORD_IDX_W;

    localparam int HALF_LO = 0;
    localparam int HALF_HI = 1;

    typedef union packed {
        logic [BUS_DATA_W-1:0]      word;
        logic [1:0][BUS_HALF_W-1:0] half;       // Index with HALF_LO / HALF_HI
    } mem_word_u;

endpackage

`default_nettype wire

// File: hw/sdram_port_pkg.sv
// Half-word port widths, queue sizing and sequencer state codes
`default_nettype none

package sdram_port_pkg;

    // Half-word port
    localparam int HADDR_W = 24;                // Word index plus half select
    localparam int HDATA_W = 16;
    localparam int DQM_W   = 2;                 // One disable bit per byte

    // Request queue
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_CNT_W = 3;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // --------------------
    // Sequencer states
    // --------------------
    localparam int SEQ_ST_W = 2;

    localparam logic [SEQ_ST_W-1:0] SEQ_IDLE   = 2'd0;
    localparam logic [SEQ_ST_W-1:0] SEQ_LO     = 2'd1;  // Low half outstanding
    localparam logic [SEQ_ST_W-1:0] SEQ_HI     = 2'd2;  // High half outstanding
    localparam logic [SEQ_ST_W-1:0] SEQ_FINISH = 2'd3;  // Read word ready

endpackage

`default_nettype wire

// File: hw/bus_window_port.sv
// Bus window decoder and request producer
// Tracks the pending read and holds the returned word
`timescale 1ns/1ps
`default_nettype none

module bus_window_port
    import bridge_bus_pkg::*;
(
    input  logic                  sysClock,
    input  logic                  rst_n,

    input  logic [BUS_ADDR_W-1:0] mem_addr,
    input  logic [BUS_DATA_W-1:0] mem_wdata,
    input  logic [BUS_MASK_W-1:0] mem_wmask,
    input  logic                  mem_rstrb,
    output logic [BUS_DATA_W-1:0] mem_rdata,
    output logic                  mem_rbusy,
    output logic                  mem_wbusy,

    output logic                  push,
    output logic [REQ_W-1:0]      push_entry,
    input  logic                  full,

    input  logic                  rd_done,
    input  mem_word_u             rd_word
);

    logic in_window;
    logic wr_strobe;
    logic rd_req;
    logic rd_pend;

    assign in_window = (mem_addr[ADDR_TAG_LSB +: 4] == WINDOW_TAG);
    assign wr_strobe = |mem_wmask;
    assign rd_req    = in_window && mem_rstrb;

    assign push      = in_window && (wr_strobe || mem_rstrb);
    assign mem_wbusy = full;            // Queue full holds off posted writes
    assign mem_rbusy = rd_pend;

    // Pack the request, writes win if both strobes show up
    always_comb begin
        push_entry[REQ_WE_BIT]                   = wr_strobe;
        push_entry[REQ_IDX_LSB +: WORD_IDX_W]    = mem_addr[ADDR_IDX_LSB +: WORD_IDX_W];
        push_entry[REQ_DATA_LSB +: BUS_DATA_W]   = mem_wdata;
        push_entry[REQ_MASK_LSB +: BUS_MASK_W]   = mem_wmask;
    end

    // --------------------
    // Read tracking
    // --------------------
    always_ff @(posedge sysClock) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
        end else if (rd_done) begin
            rd_pend <= 1'b0;
        end else if (rd_req) begin
            rd_pend <= 1'b1;
        end
    end

    always_ff @(posedge sysClock) begin
        if (rd_done) begin
            mem_rdata <= rd_word.word;  // Held until the next read returns
        end
    end

    // Bus must respect both busy flags
    a_no_strobe_when_busy: assert property (@(posedge sysClock) disable iff (!rst_n)
        (mem_rbusy || mem_wbusy) |-> !(mem_rstrb || wr_strobe));

    // Sequencer only completes a read that this side is waiting for
    a_rd_done_pending: assert property (@(posedge sysClock) disable iff (!rst_n)
        rd_done |-> rd_pend);

endmodule

`default_nettype wire

// File: hw/request_fifo.sv
// Four-entry fall-through request queue with full and empty flags
`timescale 1ns/1ps
`default_nettype none

module request_fifo
    import bridge_bus_pkg::*;
    import sdram_port_pkg::*;
(
    input  logic             sysClock,
    input  logic             rst_n,

    input  logic             push,
    input  logic [REQ_W-1:0] push_entry,
    input  logic             pop,

    output logic [REQ_W-1:0] head_entry,
    output logic             empty,
    output logic             full
);

    logic [REQ_W-1:0]      entries [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;

    assign head_entry = entries[rd_ptr];    // Fall-through head
    assign empty      = (count == '0);
    assign full       = (count == FIFO_CNT_W'(FIFO_DEPTH));

    // Entry storage
    always_ff @(posedge sysClock) begin
        if (push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge sysClock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
            if (pop)  rd_ptr <= rd_ptr + 1'b1;

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_push_full: assert property (@(posedge sysClock) disable iff (!rst_n)
        push |-> !full);

    a_no_pop_empty: assert property (@(posedge sysClock) disable iff (!rst_n)
        pop |-> !empty);

endmodule

`default_nettype wire

// File: hw/halfword_sequencer.sv
// Half-word access sequencer, low half first
// Splits queued word requests and rebuilds read words
`timescale 1ns/1ps
`default_nettype none

module halfword_sequencer
    import bridge_bus_pkg::*;
    import sdram_port_pkg::*;
(
    input  logic               sysClock,
    input  logic               rst_n,

    input  logic               empty,
    input  logic [REQ_W-1:0]   head_entry,
    output logic               pop,

    output logic               rd_done,
    output mem_word_u          rd_word,

    output logic               hw_req,
    output logic               hw_we,
    output logic [HADDR_W-1:0] hw_addr,
    output logic [HDATA_W-1:0] hw_wdata,
    output logic [DQM_W-1:0]   hw_dqm,
    input  logic               hw_ack,
    input  logic [HDATA_W-1:0] hw_rdata
);

    logic [SEQ_ST_W-1:0]   state;
    logic                  hi_go_q;             // Issue high half this cycle

    // Head entry fields
    logic                  head_we;
    logic [WORD_IDX_W-1:0] head_idx;
    mem_word_u             head_data;
    logic [BUS_MASK_W-1:0] head_mask;
    logic                  head_need_lo;
    logic                  head_need_hi;

    // Request being worked on
    logic                  cur_we;
    logic [WORD_IDX_W-1:0] cur_idx;
    mem_word_u             cur_data;
    logic [BUS_MASK_W-1:0] cur_mask;
    logic                  cur_need_hi;

    // Fields driving the port this cycle
    logic                  sel_we;
    logic [WORD_IDX_W-1:0] sel_idx;
    mem_word_u             sel_data;
    logic [BUS_MASK_W-1:0] sel_mask;
    logic                  sel_hi;
    logic [DQM_W-1:0]      sel_bytes;

    assign head_we      = head_entry[REQ_WE_BIT];
    assign head_idx     = head_entry[REQ_IDX_LSB +: WORD_IDX_W];
    assign head_data    = head_entry[REQ_DATA_LSB +: BUS_DATA_W];
    assign head_mask    = head_entry[REQ_MASK_LSB +: BUS_MASK_W];
    assign head_need_lo = !head_we || (|head_mask[DQM_W-1:0]);
    assign head_need_hi = !head_we || (|head_mask[BUS_MASK_W-1:DQM_W]);

    assign pop     = (state == SEQ_IDLE) && !empty;
    assign rd_done = (state == SEQ_FINISH);

    // --------------------
    // Port drive, head fields while idle so the first access leaves with pop
    // --------------------
    always_comb begin
        if (state == SEQ_IDLE) begin
            sel_we   = head_we;
            sel_idx  = head_idx;
            sel_data = head_data;
            sel_mask = head_mask;
            sel_hi   = !head_need_lo;
        end else begin
            sel_we   = cur_we;
            sel_idx  = cur_idx;
            sel_data = cur_data;
            sel_mask = cur_mask;
            sel_hi   = (state == SEQ_HI);
        end
        sel_bytes = sel_hi ? sel_mask[BUS_MASK_W-1:DQM_W] : sel_mask[DQM_W-1:0];
    end

    assign hw_req   = (pop && (head_need_lo || head_need_hi)) || hi_go_q;
    assign hw_we    = sel_we;
    assign hw_addr  = {sel_idx, sel_hi};
    assign hw_wdata = sel_hi ? sel_data.half[HALF_HI] : sel_data.half[HALF_LO];
    assign hw_dqm   = sel_we ? ~sel_bytes : '0;    // Reads keep all bytes

    // --------------------
    // FSM
    // --------------------
    always_ff @(posedge sysClock) begin
        if (!rst_n) begin
            state   <= SEQ_IDLE;
            hi_go_q <= 1'b0;
        end else begin
            hi_go_q <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (pop && head_need_lo)      state <= SEQ_LO;
                    else if (pop && head_need_hi) state <= SEQ_HI;
                end
                SEQ_LO: begin
                    if (hw_ack && cur_need_hi) begin
                        state   <= SEQ_HI;
                        hi_go_q <= 1'b1;
                    end else if (hw_ack) begin
                        state   <= SEQ_IDLE;    // Low-only write
                    end
                end
                SEQ_HI: begin
                    if (hw_ack) state <= cur_we ? SEQ_IDLE : SEQ_FINISH;
                end
                default: state <= SEQ_IDLE;     // Finish lasts one cycle
            endcase
        end
    end

    // Request capture and read assembly
    always_ff @(posedge sysClock) begin
        if (pop) begin
            cur_we      <= head_we;
            cur_idx     <= head_idx;
            cur_data    <= head_data;
            cur_mask    <= head_mask;
            cur_need_hi <= head_need_hi;
        end
        if (hw_ack && (state == SEQ_LO)) rd_word.half[HALF_LO] <= hw_rdata;
        if (hw_ack && (state == SEQ_HI)) rd_word.half[HALF_HI] <= hw_rdata;
    end

    // Device may only acknowledge an access that went out on an earlier cycle
    a_ack_outstanding: assert property (@(posedge sysClock) disable iff (!rst_n)
        hw_ack |-> ((state == SEQ_LO) || ((state == SEQ_HI) && !hi_go_q)));

endmodule

`default_nettype wire

// File: hw/sdram_bridge_top.sv
// Bus to half-word bridge top level
// Window port, request queue and half-word sequencer
`timescale 1ns/1ps
`default_nettype none

module sdram_bridge_top
    import bridge_bus_pkg::*;
    import sdram_port_pkg::*;
(
    input  logic                  sysClock,
    input  logic                  rst_n,

    // Processor bus
    input  logic [BUS_ADDR_W-1:0] mem_addr,
    input  logic [BUS_DATA_W-1:0] mem_wdata,
    input  logic [BUS_MASK_W-1:0] mem_wmask,
    input  logic                  mem_rstrb,
    output logic [BUS_DATA_W-1:0] mem_rdata,
    output logic                  mem_rbusy,
    output logic                  mem_wbusy,

    // Half-word device
    output logic                  hw_req,
    output logic                  hw_we,
    output logic [HADDR_W-1:0]    hw_addr,
    output logic [HDATA_W-1:0]    hw_wdata,
    output logic [DQM_W-1:0]      hw_dqm,
    input  logic                  hw_ack,
    input  logic [HDATA_W-1:0]    hw_rdata
);

    logic             push;
    logic [REQ_W-1:0] push_entry;
    logic             full;
    logic             empty;
    logic [REQ_W-1:0] head_entry;
    logic             pop;
    logic             rd_done;
    mem_word_u        rd_word;

    bus_window_port u_port (
        .sysClock, .rst_n,
        .mem_addr, .mem_wdata, .mem_wmask, .mem_rstrb,
        .mem_rdata, .mem_rbusy, .mem_wbusy,
        .push, .push_entry, .full,
        .rd_done, .rd_word
    );

    request_fifo u_fifo (
        .sysClock, .rst_n,
        .push, .push_entry, .pop,
        .head_entry, .empty, .full
    );

    halfword_sequencer u_seq (
        .sysClock, .rst_n,
        .empty, .head_entry, .pop,
        .rd_done, .rd_word,
        .hw_req, .hw_we, .hw_addr, .hw_wdata, .hw_dqm,
        .hw_ack, .hw_rdata
    );

endmodule

`default_nettype wire

// File: verification/halfword_mem_model.sv
// Behavioural half-word memory behind the request/acknowledge port
// Random acknowledge latency of 1 to 6 cycles, or 6 in slow mode
`timescale 1ns/1ps
`default_nettype none

module halfword_mem_model (
    input  wire        sysClock,
    input  wire        rst_n,
    input  wire        slow,
    input  wire        hw_req,
    input  wire        hw_we,
    input  wire [23:0] hw_addr,
    input  wire [15:0] hw_wdata,
    input  wire [1:0]  hw_dqm,
    output logic       hw_ack,
    output logic [15:0] hw_rdata,
    output logic       busy
);

    logic [15:0] mem [logic [23:0]];
    integer      seed = 32'hc8e6_4b3d;
    int          wait_cnt;
    logic        pending;
    logic        lat_we;
    logic [23:0] lat_addr;
    logic [15:0] lat_data;
    logic [1:0]  lat_dqm;
    logic [15:0] merged;

    assign busy = pending || hw_ack;

    initial begin
        hw_ack   = 1'b0;
        hw_rdata = 16'h0000;
    end

    always @(posedge sysClock) begin
        hw_ack <= 1'b0;
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (hw_req) begin
            pending  <= 1'b1;
            lat_we   <= hw_we;
            lat_addr <= hw_addr;
            lat_data <= hw_wdata;
            lat_dqm  <= hw_dqm;
            wait_cnt <= slow ? 6 : int'({$random(seed)} % 6) + 1;
        end else if (pending) begin
            if (wait_cnt <= 1) begin
                hw_ack  <= 1'b1;
                pending <= 1'b0;
                merged  = mem.exists(lat_addr) ? mem[lat_addr] : 16'h0000;  // Unwritten is zero
                if (lat_we) begin
                    if (!lat_dqm[0]) merged[7:0]  = lat_data[7:0];
                    if (!lat_dqm[1]) merged[15:8] = lat_data[15:8];
                    mem[lat_addr] = merged;
                end else begin
                    hw_rdata <= merged;
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/bridge_checker.sv
// Read data compare, access counting and per-test report for the bridge
`timescale 1ns/1ps
`default_nettype none

module bridge_checker (
    input  wire        sysClock,
    input  wire        rst_n,
    input  wire        mem_rbusy,
    input  wire        mem_wbusy,
    input  wire [31:0] mem_rdata,
    input  wire        hw_req,
    input  wire [31:0] exp_rdata,
    input  wire        quiet_chk,
    input  wire        test_end,
    input  int         test_num,
    input  int         exp_count,
    input  int         exp_reads,
    input  wire        need_wbusy,
    output int         err_count,
    output int         tests_passed,
    output int         tests_failed
);

    logic        rbusy_q;
    logic        saw_wbusy;
    logic [31:0] exp_q;                 // Expected word of the read in flight
    int          req_cnt;
    int          rd_cnt;
    int          test_errs;

    initial begin
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
    end

    // Testbench inputs change on the falling edge and are sampled here
    always @(posedge sysClock) begin
        if (!rst_n) begin
            rbusy_q   = 1'b0;
            saw_wbusy = 1'b0;
            exp_q     = '0;
            req_cnt   = 0;
            rd_cnt    = 0;
            test_errs = 0;
        end else begin
            // The bus may start the next read as soon as busy drops
            if (!rbusy_q && mem_rbusy) exp_q = exp_rdata;
            // Read result lands with the falling busy flag
            if (rbusy_q && !mem_rbusy) begin
                rd_cnt++;
                if (mem_rdata !== exp_q) begin
                    $display("mismatch at %0t ns: mem_rdata got %h expected %h",
                             $time, mem_rdata, exp_q);
                    test_errs++;
                end
            end
            if (quiet_chk && (mem_rbusy || mem_wbusy || hw_req)) begin
                $display("at %0t ns the bridge was active while it should stay idle", $time);
                test_errs++;
            end
            if (mem_wbusy) saw_wbusy = 1'b1;
            if (hw_req) req_cnt++;

            if (test_end) begin
                if (req_cnt != exp_count) begin
                    $display("mismatch at %0t ns: hw_req count got %0d expected %0d",
                             $time, req_cnt, exp_count);
                    test_errs++;
                end
                if (rd_cnt != exp_reads) begin
                    $display("test %0d completed %0d reads instead of %0d",
                             test_num, rd_cnt, exp_reads);
                    test_errs++;
                end
                if (need_wbusy && !saw_wbusy) begin
                    $display("test %0d never saw the queue full flag", test_num);
                    test_errs++;
                end
                if (test_errs == 0) begin
                    $display("test %0d passed, %0d half-word accesses", test_num, req_cnt);
                    tests_passed++;
                end else begin
                    $display("test %0d failed with %0d errors", test_num, test_errs);
                    tests_failed++;
                end
                err_count += test_errs;
                test_errs  = 0;
                req_cnt    = 0;
                rd_cnt     = 0;
                saw_wbusy  = 1'b0;
            end
            rbusy_q = mem_rbusy;
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_sdram_bridge.sv
// Testbench top for the bus to half-word bridge
// Clock, reset, data-file stimulus, memory model and checker
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_bridge
    import bridge_bus_pkg::*;
    import sdram_port_pkg::*;
();

    localparam int WAIT_LIMIT = 2000;           // Cycles per wait loop

    logic                  sysClock;
    logic                  rst_n;
    logic [BUS_ADDR_W-1:0] mem_addr;
    logic [BUS_DATA_W-1:0] mem_wdata;
    logic [BUS_MASK_W-1:0] mem_wmask;
    logic                  mem_rstrb;
    logic [BUS_DATA_W-1:0] mem_rdata;
    logic                  mem_rbusy;
    logic                  mem_wbusy;
    logic                  hw_req;
    logic                  hw_we;
    logic [HADDR_W-1:0]    hw_addr;
    logic [HDATA_W-1:0]    hw_wdata;
    logic [DQM_W-1:0]      hw_dqm;
    logic                  hw_ack;
    logic [HDATA_W-1:0]    hw_rdata;
    logic                  mdl_busy;

    logic                  slow;
    logic                  quiet_chk;
    logic                  test_end;
    logic                  need_wb;
    logic [BUS_DATA_W-1:0] exp_rdata;
    int                    cur_test;
    int                    exp_sum;
    int                    exp_rd;
    int                    err_count;
    int                    tests_passed;
    int                    tests_failed;
    logic                  hung;

    int          fd;
    int          code;
    string       line;
    logic [31:0] rec_test, rec_op, rec_flags, rec_addr, rec_wdata, rec_mask, rec_exp, rec_cnt;

    sdram_bridge_top UUT (
        .sysClock, .rst_n,
        .mem_addr, .mem_wdata, .mem_wmask, .mem_rstrb,
        .mem_rdata, .mem_rbusy, .mem_wbusy,
        .hw_req, .hw_we, .hw_addr, .hw_wdata, .hw_dqm,
        .hw_ack, .hw_rdata
    );

    halfword_mem_model u_mem (
        .sysClock, .rst_n, .slow,
        .hw_req, .hw_we, .hw_addr, .hw_wdata, .hw_dqm,
        .hw_ack, .hw_rdata, .busy(mdl_busy)
    );

    bridge_checker u_chk (
        .sysClock, .rst_n, .mem_rbusy, .mem_wbusy, .mem_rdata, .hw_req,
        .exp_rdata, .quiet_chk, .test_end, .test_num(cur_test), .exp_count(exp_sum),
        .exp_reads(exp_rd), .need_wbusy(need_wb), .err_count, .tests_passed, .tests_failed
    );

    initial begin
        sysClock = 1'b0;
        forever #20 sysClock = ~sysClock;
    end

    // Bus may only start while both busy flags are low
    task automatic wait_ready();
        int n;
        n = 0;
        while ((mem_rbusy || mem_wbusy) && n < WAIT_LIMIT) begin
            @(negedge sysClock);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("timeout at %0t ns, bus busy flags never dropped", $time);
            hung = 1'b1;
        end
    endtask

    // Wait until queue, sequencer and memory have all gone quiet
    task automatic drain();
        int n;
        int quiet;
        n = 0;
        quiet = 0;
        while (quiet < 4 && n < WAIT_LIMIT) begin
            @(negedge sysClock);
            n++;
            if (!mdl_busy && !hw_req && !mem_rbusy && !mem_wbusy) quiet++;
            else quiet = 0;
        end
        if (n >= WAIT_LIMIT) begin
            $display("timeout at %0t ns, bridge never went idle", $time);
            hung = 1'b1;
        end
    endtask

    task automatic close_test();
        drain();
        slow     = 1'b0;
        test_end = 1'b1;
        @(negedge sysClock);
        test_end = 1'b0;
    endtask

    task automatic run_record();
        wait_ready();
        if (!hung) begin
            slow     = rec_flags[0];
            need_wb  = need_wb | rec_flags[1];
            exp_sum += int'(rec_cnt);
            mem_addr = rec_addr;
            if (rec_op == 0) begin
                mem_wdata = rec_wdata;
                mem_wmask = rec_mask[BUS_MASK_W-1:0];
            end else begin
                exp_rdata = rec_exp;
                mem_rstrb = 1'b1;
                if (!rec_flags[2]) exp_rd++;    // Reads outside the window never go busy
            end
            if (rec_flags[2]) quiet_chk = 1'b1;
            @(negedge sysClock);
            mem_wmask = '0;
            mem_rstrb = 1'b0;
            if (rec_flags[2]) begin
                drain();
                quiet_chk = 1'b0;
            end
        end
    endtask

    initial begin
        rst_n = 1'b0;
        mem_addr = '0;
        mem_wdata = '0;
        mem_wmask = '0;
        mem_rstrb = 1'b0;
        slow = 1'b0;
        quiet_chk = 1'b0;
        test_end = 1'b0;
        need_wb = 1'b0;
        exp_rdata = '0;
        exp_sum = 0;
        exp_rd = 0;
        hung = 1'b0;
        cur_test = 1;
        repeat (3) @(negedge sysClock);
        rst_n = 1'b1;

        // --------------------
        // Test 1 keeps the bridge idle after reset
        // --------------------
        quiet_chk = 1'b1;
        repeat (8) @(negedge sysClock);
        quiet_chk = 1'b0;
        close_test();

        fd = $fopen("verification/bridge_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            hung = 1'b1;
        end else begin
            cur_test = 0;
            while (!$feof(fd) && !hung) begin
                line = "";
                code = $fgets(line, fd);
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    code = $sscanf(line, "%d %d %h %h %h %h %h %d", rec_test, rec_op,
                                   rec_flags, rec_addr, rec_wdata, rec_mask, rec_exp, rec_cnt);
                    if (code == 8) begin
                        if (int'(rec_test) != cur_test) begin
                            if (cur_test != 0) close_test();
                            cur_test = int'(rec_test);
                            exp_sum  = 0;
                            exp_rd   = 0;
                            need_wb  = 1'b0;
                        end
                        run_record();
                    end
                end
            end
            if (cur_test != 0 && !hung) close_test();
            $fclose(fd);
        end

        @(negedge sysClock);
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
        if (hung) $display("run stopped early");
        if (hung || err_count != 0 || tests_failed != 0 || tests_passed == 0) begin
            $display("** FAIL **");
        end else begin
            $display("** PASS **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
hw/bridge_bus_pkg.sv
hw/sdram_port_pkg.sv
hw/bus_window_port.sv
hw/request_fifo.sv
hw/halfword_sequencer.sv
hw/sdram_bridge_top.sv
verification/halfword_mem_model.sv
verification/bridge_checker.sv
verification/tb_sdram_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module tb_sdram_bridge \
    -o sim_bridge > build.log 2>&1 \
    && ./obj_dir/sim_bridge > sim.log 2>&1 \
    || { cat build.log; test -f sim.log && cat sim.log; echo "build or run failed"; exit 1; }

cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1 || exit 0

// File: verification/bridge_testdata.txt
# test op(0 write, 1 read) flags(1 slow, 2 expect full, 4 stay idle) addr wdata mask
# expected read word, expected half-word accesses for the record
2 0 0 40000010 deadbeef f 00000000 2
2 1 0 40000010 00000000 0 deadbeef 2
3 0 0 40000020 11223344 f 00000000 2
3 0 0 40000020 aaaabbbb 3 00000000 1
3 0 0 40000020 ccdd0000 8 00000000 1
3 1 0 40000020 00000000 0 cc22bbbb 2
3 0 0 40000024 00550000 4 00000000 1
3 0 0 40000024 000000ee 1 00000000 1
3 1 0 40000024 00000000 0 005500ee 2
4 0 4 50000030 12345678 f 00000000 0
4 1 4 30000030 00000000 0 00000000 0
4 0 0 40000040 cafef00d f 00000000 2
4 1 0 4e000040 00000000 0 cafef00d 2
5 0 3 40000100 05000001 f 00000000 2
5 0 3 40000104 05000002 f 00000000 2
5 0 3 40000108 05000003 f 00000000 2
5 0 3 4000010c 05000004 f 00000000 2
5 0 3 40000110 05000005 f 00000000 2
5 1 1 40000100 00000000 0 05000001 2
5 1 1 40000104 00000000 0 05000002 2
5 1 1 40000108 00000000 0 05000003 2
5 1 1 4000010c 00000000 0 05000004 2
5 1 1 40000110 00000000 0 05000005 2
6 0 0 40000200 600000a1 f 00000000 2
6 1 0 40000200 00000000 0 600000a1 2
6 0 0 40000204 600000b2 3 00000000 1
6 1 0 40000204 00000000 0 000000b2 2
6 0 0 40000208 12345678 c 00000000 1
6 1 0 40000208 00000000 0 12340000 2
6 0 0 40000200 ffff0000 c 00000000 1
6 0 0 4000020c 0badcafe f 00000000 2
6 1 0 40000200 00000000 0 ffff00a1 2
6 1 0 4000020c 00000000 0 0badcafe 2
6 0 0 40000204 77000000 8 00000000 1
6 1 0 40000204 00000000 0 770000b2 2
